// ==== design/dlrom.sv ====
// Byte-wide download RAM with one registered read port and one write port
`timescale 1ns/1ps

module dlrom #(
	parameter int aw = 13
) (
	input  logic                CL0,

	// Read port
	input  logic [aw-1:0]       rd_addr,
	output njrom_pkg::rom_byte_t rd_data,

	// Download write port
	input  logic [aw-1:0]       wr_addr,
	input  njrom_pkg::rom_byte_t wr_data,
	input  logic                wr_en
);

	njrom_pkg::rom_byte_t mem [0:(2**aw)-1];

	// Registered read, old data on a same-edge write
	always_ff @(posedge CL0) begin
		rd_data <= mem[rd_addr];
	end

	always_ff @(posedge CL0) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

endmodule

// ==== design/gfx_rom.sv ====
// Tile ROM: 32-bit words assembled from four downloaded byte lanes
`timescale 1ns/1ps

module gfx_rom (
	input  logic                            CL0,

	// Video read port
	input  logic [njrom_pkg::gfx_aw-1:0]    rd_addr,
	output njrom_pkg::gfx_word_t            rd_data,

	// Byte writes within this region
	input  logic [njrom_pkg::region_aw-1:0] wr_addr,
	input  njrom_pkg::rom_byte_t            wr_data,
	input  logic                            wr_en
);

	logic [njrom_pkg::gfx_aw-1:0] lane_addr;
	logic [1:0]                   lane_sel;
	logic [3:0]                   lane_we;

	// Bit 14 keeps the upper half, bits 13 and 0 go into the lane number
	assign lane_addr = {wr_addr[14], wr_addr[12:1]};

	// Bit 13 picks within a pair, bit 0 picks the pair
	assign lane_sel = {wr_addr[0], wr_addr[13]};

	always_comb begin
		lane_we = 4'b0000;
		if (wr_en) begin
			lane_we[lane_sel] = 1'b1;
		end
	end

	for (genvar lane = 0; lane < 4; lane++) begin : g_lane
		dlrom #(
			.aw(njrom_pkg::gfx_aw)
		) lane_rom_i (
			.CL0    (CL0),
			.rd_addr(rd_addr),
			.rd_data(rd_data[8*lane +: 8]),
			.wr_addr(lane_addr),
			.wr_data(wr_data),
			.wr_en  (lane_we[lane])
		);
	end

endmodule

// ==== design/njrom_pkg.sv ====
// ROM block shared definitions: address widths, data types and region codes
package njrom_pkg;

	// Download byte address, four 32 KiB regions
	localparam int dl_aw = 17;

	// Byte address inside one region
	localparam int region_aw = 15;

	// Tile ROM word address
	localparam int gfx_aw = 13;

	typedef logic [7:0] rom_byte_t;

	typedef logic [31:0] gfx_word_t;

	// Region code, taken from the top two download address bits
	typedef enum logic [1:0] {
		region_fg   = 2'd0,
		region_bg   = 2'd1,
		region_cpu0 = 2'd2,
		region_cpu1 = 2'd3
	} rom_region_e;

endpackage

// ==== design/njrom_top.sv ====
// Arcade ROM block: download decoder feeding two tile ROMs and two program ROMs
`timescale 1ns/1ps

module njrom_top (
	input  logic                            CL0,
	input  logic                            rst_n,

	// Loader byte stream
	input  logic [njrom_pkg::dl_aw-1:0]     dl_addr,
	input  njrom_pkg::rom_byte_t            dl_data,
	input  logic                            dl_wr,

	// Foreground and background tile reads
	input  logic [njrom_pkg::gfx_aw-1:0]    fg_addr,
	input  logic [njrom_pkg::gfx_aw-1:0]    bg_addr,
	output njrom_pkg::gfx_word_t            fg_data,
	output njrom_pkg::gfx_word_t            bg_data,

	// Program reads for the two CPUs
	input  logic [njrom_pkg::region_aw-1:0] cpu0_addr,
	input  logic [njrom_pkg::region_aw-1:0] cpu1_addr,
	output njrom_pkg::rom_byte_t            cpu0_data,
	output njrom_pkg::rom_byte_t            cpu1_data
);

	logic [njrom_pkg::region_aw-1:0] wr_addr;
	njrom_pkg::rom_byte_t            wr_data;
	logic                            wr_fg;
	logic                            wr_bg;
	logic                            wr_cpu0;
	logic                            wr_cpu1;

	rom_download_decoder rom_download_decoder_i (
		.CL0    (CL0),
		.rst_n  (rst_n),
		.dl_addr(dl_addr),
		.dl_data(dl_data),
		.dl_wr  (dl_wr),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_fg  (wr_fg),
		.wr_bg  (wr_bg),
		.wr_cpu0(wr_cpu0),
		.wr_cpu1(wr_cpu1)
	);

	// Region 0
	gfx_rom fg_rom_i (
		.CL0    (CL0),
		.rd_addr(fg_addr),
		.rd_data(fg_data),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (wr_fg)
	);

	// Region 1
	gfx_rom bg_rom_i (
		.CL0    (CL0),
		.rd_addr(bg_addr),
		.rd_data(bg_data),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (wr_bg)
	);

	// Region 2
	dlrom #(
		.aw(njrom_pkg::region_aw)
	) cpu0_rom_i (
		.CL0    (CL0),
		.rd_addr(cpu0_addr),
		.rd_data(cpu0_data),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (wr_cpu0)
	);

	// Region 3
	dlrom #(
		.aw(njrom_pkg::region_aw)
	) cpu1_rom_i (
		.CL0    (CL0),
		.rd_addr(cpu1_addr),
		.rd_data(cpu1_data),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_en  (wr_cpu1)
	);

endmodule

// ==== design/rom_download_decoder.sv ====
// Download decoder that registers the incoming byte and strobes the matching ROM region
`timescale 1ns/1ps

module rom_download_decoder (
	input  logic                            CL0,
	input  logic                            rst_n,

	// Byte stream from the loader
	input  logic [njrom_pkg::dl_aw-1:0]     dl_addr,
	input  njrom_pkg::rom_byte_t            dl_data,
	input  logic                            dl_wr,

	// Shared write bus to the memories
	output logic [njrom_pkg::region_aw-1:0] wr_addr,
	output njrom_pkg::rom_byte_t            wr_data,

	// One strobe per region
	output logic                            wr_fg,
	output logic                            wr_bg,
	output logic                            wr_cpu0,
	output logic                            wr_cpu1
);

	logic [njrom_pkg::dl_aw-1:0] dl_addr_q;
	njrom_pkg::rom_byte_t        dl_data_q;
	logic                        dl_wr_q;

	njrom_pkg::rom_region_e      region;

	// Write flag is the only control state
	always_ff @(posedge CL0 or negedge rst_n) begin
		if (!rst_n) begin
			dl_wr_q <= 1'b0;
		end else begin
			dl_wr_q <= dl_wr;
		end
	end

	// Address and byte follow the flag by the same edge
	always_ff @(posedge CL0) begin
		dl_addr_q <= dl_addr;
		dl_data_q <= dl_data;
	end

	// Top two bits pick the region
	assign region = njrom_pkg::rom_region_e'(
		dl_addr_q[njrom_pkg::dl_aw-1:njrom_pkg::region_aw]);

	assign wr_addr = dl_addr_q[njrom_pkg::region_aw-1:0];
	assign wr_data = dl_data_q;

	always_comb begin
		wr_fg   = 1'b0;
		wr_bg   = 1'b0;
		wr_cpu0 = 1'b0;
		wr_cpu1 = 1'b0;
		if (dl_wr_q) begin
			unique case (region)
				njrom_pkg::region_fg: begin
					wr_fg = 1'b1;
				end
				njrom_pkg::region_bg: begin
					wr_bg = 1'b1;
				end
				njrom_pkg::region_cpu0: begin
					wr_cpu0 = 1'b1;
				end
				njrom_pkg::region_cpu1: begin
					wr_cpu1 = 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ROM block simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module njrom_tb -f verilog.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vnjrom_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

// ==== tests/njrom_assertions.sv ====
// Download decoder checks: strobe exclusivity, reset behavior and strobe cause
`timescale 1ns/1ps

module rom_download_decoder_assertions (
	input logic CL0,
	input logic rst_n,
	input logic dl_wr,
	input logic wr_fg,
	input logic wr_bg,
	input logic wr_cpu0,
	input logic wr_cpu1
);

	logic any_wr;

	assign any_wr = wr_fg | wr_bg | wr_cpu0 | wr_cpu1;

	one_strobe: assert property (@(posedge CL0) $onehot0({wr_fg, wr_bg, wr_cpu0, wr_cpu1}))
		else $error("More than one region strobe high");

	quiet_in_reset: assert property (@(posedge CL0) !rst_n |-> !any_wr)
		else $error("Region strobe high during reset");

	// A strobe follows a registered write flag
	strobe_cause: assert property (@(posedge CL0) disable iff (!rst_n) any_wr |-> $past(dl_wr))
		else $error("Region strobe without a write one cycle earlier");

endmodule

bind rom_download_decoder rom_download_decoder_assertions rom_download_decoder_assertions_i (.*);

// ==== tests/njrom_tb.sv ====
// Testbench for the ROM block: table-driven downloads and readbacks against a byte model
`timescale 1ns/1ps

module njrom_tb;

	localparam int dl_rows = 14;
	localparam int rd_rows = 10;
	localparam int rand_count = 400;
	localparam int rand_reads = 200;
	localparam int timeout_cycles = dl_rows + rd_rows + rand_count * 2 + 20;

	typedef struct packed {
		logic [njrom_pkg::dl_aw-1:0] addr;
		njrom_pkg::rom_byte_t        data;
		logic                        wr;
	} dl_row_t;

	typedef struct packed {
		njrom_pkg::rom_region_e          kind;
		logic [njrom_pkg::region_aw-1:0] addr;
		njrom_pkg::gfx_word_t            expected;
		logic                            from_model;
	} rd_row_t;

	logic                            CL0;
	logic                            rst_n;
	logic [njrom_pkg::dl_aw-1:0]     dl_addr;
	njrom_pkg::rom_byte_t            dl_data;
	logic                            dl_wr;
	logic [njrom_pkg::gfx_aw-1:0]    fg_addr;
	logic [njrom_pkg::gfx_aw-1:0]    bg_addr;
	logic [njrom_pkg::region_aw-1:0] cpu0_addr;
	logic [njrom_pkg::region_aw-1:0] cpu1_addr;
	njrom_pkg::gfx_word_t            fg_data;
	njrom_pkg::gfx_word_t            bg_data;
	njrom_pkg::rom_byte_t            cpu0_data;
	njrom_pkg::rom_byte_t            cpu1_data;

	dl_row_t dl_tab [dl_rows];
	rd_row_t rd_tab [rd_rows];

	// One byte array per region
	njrom_pkg::rom_byte_t model_mem [0:3][0:32767];

	njrom_pkg::rom_region_e          cand_kind [$];
	logic [njrom_pkg::region_aw-1:0] cand_addr [$];

	int gfx_errors = 0;
	int cpu_errors = 0;

	njrom_top njrom_top_i (.*);

	always #50 CL0 = ~CL0;

	task automatic fill_tables();
		// CPU regions, same offset in both
		dl_tab[0]  = '{17'h10123, 8'h3c, 1'b1};
		dl_tab[1]  = '{17'h18123, 8'hc3, 1'b1};
		dl_tab[2]  = '{17'h17fff, 8'h81, 1'b1};
		dl_tab[3]  = '{17'h18000, 8'h42, 1'b1};
		// Four lanes of foreground word 0x1234
		dl_tab[4]  = '{17'h04468, 8'h11, 1'b1};
		dl_tab[5]  = '{17'h06468, 8'h22, 1'b1};
		dl_tab[6]  = '{17'h04469, 8'h33, 1'b1};
		dl_tab[7]  = '{17'h06469, 8'h44, 1'b1};
		// Same offsets in background
		dl_tab[8]  = '{17'h0c468, 8'ha1, 1'b1};
		dl_tab[9]  = '{17'h0e468, 8'hb2, 1'b1};
		dl_tab[10] = '{17'h0c469, 8'hc3, 1'b1};
		dl_tab[11] = '{17'h0e469, 8'hd4, 1'b1};
		// Write flag low, nothing stored
		dl_tab[12] = '{17'h10123, 8'hff, 1'b0};
		dl_tab[13] = '{17'h04468, 8'hee, 1'b0};

		rd_tab[0] = '{njrom_pkg::region_cpu0, 15'h0123, 32'h0000003c, 1'b0};
		rd_tab[1] = '{njrom_pkg::region_cpu1, 15'h0123, 32'h000000c3, 1'b0};
		rd_tab[2] = '{njrom_pkg::region_cpu0, 15'h7fff, 32'h00000081, 1'b0};
		rd_tab[3] = '{njrom_pkg::region_cpu1, 15'h0000, 32'h00000042, 1'b0};
		rd_tab[4] = '{njrom_pkg::region_fg, 15'h1234, 32'h44332211, 1'b0};
		rd_tab[5] = '{njrom_pkg::region_bg, 15'h1234, 32'hd4c3b2a1, 1'b0};
		rd_tab[6] = '{njrom_pkg::region_fg, 15'h1234, 32'h0, 1'b1};
		rd_tab[7] = '{njrom_pkg::region_bg, 15'h1234, 32'h0, 1'b1};
		rd_tab[8] = '{njrom_pkg::region_cpu0, 15'h0123, 32'h0, 1'b1};
		rd_tab[9] = '{njrom_pkg::region_cpu1, 15'h0000, 32'h0, 1'b1};
	endtask

	// Lane number is address bit 0 then bit 13
	function automatic njrom_pkg::gfx_word_t model_value(input njrom_pkg::rom_region_e kind,
			input logic [njrom_pkg::region_aw-1:0] addr);
		njrom_pkg::gfx_word_t w;
		logic [njrom_pkg::region_aw-1:0] a;
		w = '0;
		if (kind == njrom_pkg::region_fg || kind == njrom_pkg::region_bg) begin
			for (int lane = 0; lane < 4; lane++) begin
				a = {addr[12], lane[0], addr[11:0], lane[1]};
				w[8*lane +: 8] = model_mem[int'(kind)][a];
			end
		end else begin
			w[7:0] = model_mem[int'(kind)][addr];
		end
		return w;
	endfunction

	task automatic download_byte(input logic [njrom_pkg::dl_aw-1:0] addr,
			input njrom_pkg::rom_byte_t data, input logic wr);
		dl_addr = addr;
		dl_data = data;
		dl_wr = wr;
		if (wr) begin
			model_mem[addr[16:15]][addr[14:0]] = data;
		end
		@(negedge CL0);
	endtask

	task automatic check_gfx(input njrom_pkg::gfx_word_t got, input njrom_pkg::gfx_word_t exp,
			input string what);
		if (got !== exp) begin
			gfx_errors++;
			$display("Fail at %0t ns: %s returned %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_cpu(input njrom_pkg::rom_byte_t got, input njrom_pkg::rom_byte_t exp,
			input string what);
		if (got !== exp) begin
			cpu_errors++;
			$display("Fail at %0t ns: %s returned %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	// Address goes out on a falling edge, data is checked one edge later
	task automatic read_and_compare(input njrom_pkg::rom_region_e kind,
			input logic [njrom_pkg::region_aw-1:0] addr, input njrom_pkg::gfx_word_t exp);
		case (kind)
			njrom_pkg::region_fg: fg_addr = addr[12:0];
			njrom_pkg::region_bg: bg_addr = addr[12:0];
			njrom_pkg::region_cpu0: cpu0_addr = addr;
			default: cpu1_addr = addr;
		endcase
		@(negedge CL0);
		case (kind)
			njrom_pkg::region_fg: check_gfx(fg_data, exp, $sformatf("fg word %h", addr));
			njrom_pkg::region_bg: check_gfx(bg_data, exp, $sformatf("bg word %h", addr));
			njrom_pkg::region_cpu0: check_cpu(cpu0_data, exp[7:0], $sformatf("cpu0 byte %h", addr));
			default: check_cpu(cpu1_data, exp[7:0], $sformatf("cpu1 byte %h", addr));
		endcase
	endtask

	initial begin
		logic [1:0] r;
		logic [12:0] word;
		logic [14:0] a;
		int idx;
		void'($urandom(48365));
		CL0 = 1'b0;
		rst_n = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		dl_wr = 1'b0;
		fg_addr = '0;
		bg_addr = '0;
		cpu0_addr = '0;
		cpu1_addr = '0;
		fill_tables();
		repeat (2) @(negedge CL0);
		rst_n = 1'b1;

		for (int i = 0; i < dl_rows; i++) begin
			download_byte(dl_tab[i].addr, dl_tab[i].data, dl_tab[i].wr);
		end
		// Let the last byte land before reading
		download_byte('0, '0, 1'b0);
		for (int i = 0; i < rd_rows; i++) begin
			read_and_compare(rd_tab[i].kind, rd_tab[i].addr, rd_tab[i].from_model ?
				model_value(rd_tab[i].kind, rd_tab[i].addr) : rd_tab[i].expected);
		end

		// Random stream in groups of four so every tile word read is fully written
		for (int g = 0; g < rand_count / 4; g++) begin
			r = 2'($urandom_range(0, 3));
			if (r < 2) begin
				word = 13'($urandom_range(0, 8191));
				for (int lane = 0; lane < 4; lane++) begin
					download_byte({r, word[12], lane[0], word[11:0], lane[1]},
						njrom_pkg::rom_byte_t'($urandom), 1'b1);
				end
				cand_kind.push_back(njrom_pkg::rom_region_e'(r));
				cand_addr.push_back({2'b00, word});
			end else begin
				for (int k = 0; k < 4; k++) begin
					a = 15'($urandom_range(0, 32767));
					download_byte({r, a}, njrom_pkg::rom_byte_t'($urandom), 1'b1);
					cand_kind.push_back(njrom_pkg::rom_region_e'(r));
					cand_addr.push_back(a);
				end
			end
		end
		download_byte('0, '0, 1'b0);
		for (int i = 0; i < rand_reads; i++) begin
			idx = $urandom_range(0, cand_kind.size() - 1);
			read_and_compare(cand_kind[idx], cand_addr[idx],
				model_value(cand_kind[idx], cand_addr[idx]));
		end

		$display("Errors: %0d tile word, %0d program byte", gfx_errors, cpu_errors);
		if (gfx_errors + cpu_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(timeout_cycles * 100);
		$display("Timeout: run still going after %0d clock cycles", timeout_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
design/njrom_pkg.sv
design/dlrom.sv
design/rom_download_decoder.sv
design/gfx_rom.sv
design/njrom_top.sv
tests/njrom_assertions.sv
tests/njrom_tb.sv
